//--- include/dmm_settings.svh
////////////////////////////////////////
// shared widths, bus field positions and timing constants
// field indices are the lowest bit of each field on the conditioning bus
// all values assume a single clk domain with SPI oversampled
////////////////////////////////////////

`ifndef DMM_SETTINGS_SVH
`define DMM_SETTINGS_SVH

////////////////////////////////////////
// conditioning bus

`define COND_BITS          29   // 4x4 mux fields + 8 monitor + 5 single bits

`define MUX_BITS           4    // azmux, himux, himux2, adcmux: en + 3 select
`define MON_BITS           8    // monitor lines

`define IDX_AZMUX          0    // 3..0
`define IDX_HIMUX          4    // 7..4
`define IDX_HIMUX2         8    // 11..8
`define IDX_SIG_PC_SW      12   // pre-charge switch
`define IDX_LED0           13
`define IDX_MONITOR        14   // 21..14
`define IDX_ADCMUX         22   // 25..22, adc current switches
`define IDX_CMPR_LATCH     26
`define IDX_MEAS_COMPLETE  27
`define IDX_SPI_INTERRUPT  28

////////////////////////////////////////
// register bank and spi framing

`define REG_BITS           32
`define SPI_FRAME_BITS     40   // 8 bit command then 32 data bits, msb first

////////////////////////////////////////
// auto-zero modulation

`define AZ_PHASE_CYCLES    8        // clocks spent in each phase
`define AZMUX_PC_SEL       4'b1011  // enable + select 3, routes pre-charge node

`endif

//--- hw/dmm_pkg.sv
////////////////////////////////////////
// shared enum types for the measurement control core
// mode values 5..7 are left undefined, the bus goes to zero for them
////////////////////////////////////////

package dmm_pkg;

  ////////////////////////////////////////
  // output mode, low 3 bits of the mode register

  typedef enum logic [2:0] {
    MODE_LO      = 3'd0,  // bus all zero
    MODE_HI      = 3'd1,  // bus all one
    MODE_PATTERN = 3'd2,  // free running counter
    MODE_DIRECT  = 3'd3,  // bus follows direct register
    MODE_AZ      = 3'd4   // auto-zero modulation
  } mode_t;

  ////////////////////////////////////////
  // register addresses, spi command bits 6..0

  typedef enum logic [6:0] {
    REG_LED    = 7'd7,   // scratch / test register
    REG_MODE   = 7'd8,
    REG_DIRECT = 7'd9
  } reg_addr_t;

  // modulation phase
  typedef enum logic {
    AZ_PC   = 1'b0,  // pre-charge switch on, azmux on pc node
    AZ_ZERO = 1'b1   // azmux from direct register
  } az_state_t;

endpackage

//--- hw/spi_slave.sv
////////////////////////////////////////
// spi mode 0 slave, oversampled in clk domain
// spi_clk half period must be at least 4 clk cycles
// writes commit only on exactly 40 bits, short or long frames dropped
////////////////////////////////////////

`timescale 1ns/1ns
`include "dmm_settings.svh"

module spi_slave (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 spi_clk,
  input  logic                 spi_cs_n,
  input  logic                 spi_mosi,
  input  logic [`REG_BITS-1:0] rd_data,
  output logic                 spi_miso,
  output logic                 wr_stb,
  output logic                 rd_req,
  output dmm_pkg::reg_addr_t   addr,
  output logic [`REG_BITS-1:0] wr_data
);

  localparam int CMD_BITS = `SPI_FRAME_BITS - `REG_BITS;
  localparam int CNT_W    = $clog2(`SPI_FRAME_BITS) + 1;  // room to overrun

  localparam logic [CNT_W-1:0] CMD_LAST  = CNT_W'(CMD_BITS - 1);
  localparam logic [CNT_W-1:0] CMD_LEN   = CNT_W'(CMD_BITS);
  localparam logic [CNT_W-1:0] FRAME_LEN = CNT_W'(`SPI_FRAME_BITS);

  logic [2:0]           sclk_pipe;  // [0] meta, [1] sync, [2] previous
  logic [2:0]           cs_pipe;
  logic [1:0]           mosi_pipe;
  logic [CNT_W-1:0]     bit_cnt;    // rising edges seen in this frame
  logic [CMD_BITS-1:0]  cmd_q;
  logic [`REG_BITS-1:0] data_q;
  logic [`REG_BITS-1:0] tx_q;       // read shifter, msb on the pin
  logic                 rd_load;

  logic sclk_rise;
  logic sclk_fall;
  logic cs_active;
  logic frame_start;
  logic frame_end;

  ////////////////////////////////////////
  // pin synchronizers and edge detect

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sclk_pipe <= '0;
      cs_pipe   <= '1;  // deselected
      mosi_pipe <= '0;
    end
    else
    begin
      sclk_pipe <= {sclk_pipe[1:0], spi_clk};
      cs_pipe   <= {cs_pipe[1:0], spi_cs_n};
      mosi_pipe <= {mosi_pipe[0], spi_mosi};
    end
  end

  assign sclk_rise   = sclk_pipe[1] & ~sclk_pipe[2];
  assign sclk_fall   = ~sclk_pipe[1] & sclk_pipe[2];
  assign cs_active   = ~cs_pipe[1];
  assign frame_start = ~cs_pipe[1] & cs_pipe[2];
  assign frame_end   = cs_pipe[1] & ~cs_pipe[2];

  ////////////////////////////////////////
  // frame control

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      bit_cnt <= '0;
      cmd_q   <= '0;
      tx_q    <= '0;
      wr_stb  <= 1'b0;
      rd_req  <= 1'b0;
      rd_load <= 1'b0;
    end
    else
    begin
      wr_stb  <= 1'b0;
      rd_req  <= 1'b0;
      rd_load <= rd_req;  // bank answers one clock after rd_req
      if (frame_start)
      begin
        bit_cnt <= '0;
        tx_q    <= '0;
      end
      else if (cs_active && sclk_rise)
      begin
        if (bit_cnt != '1)
          bit_cnt <= bit_cnt + 1'b1;  // saturate, overlong frame stays invalid
        if (bit_cnt < CMD_LEN)
          cmd_q <= {cmd_q[CMD_BITS-2:0], mosi_pipe[1]};
        // 8th command bit arriving, read flag already sits one below the top
        if (bit_cnt == CMD_LAST && cmd_q[CMD_BITS-2])
          rd_req <= 1'b1;
      end
      else if (cs_active && sclk_fall && bit_cnt > CMD_LEN)
        tx_q <= {tx_q[`REG_BITS-2:0], 1'b0};  // next data bit after falling edge
      if (rd_load)
        tx_q <= rd_data;  // first data bit lands before first data rising edge
      if (frame_end && bit_cnt == FRAME_LEN && !cmd_q[CMD_BITS-1])
        wr_stb <= 1'b1;
    end
  end

  // data shifter, every bit after the command
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      data_q <= '0;
    else if (cs_active && sclk_rise && bit_cnt >= CMD_LEN)
      data_q <= {data_q[`REG_BITS-2:0], mosi_pipe[1]};
  end

  assign addr     = dmm_pkg::reg_addr_t'(cmd_q[CMD_BITS-2:0]);
  assign wr_data  = data_q;
  assign spi_miso = cs_active & tx_q[`REG_BITS-1];

  ////////////////////////////////////////
  // checks

  a_wr_rd_exclusive : assert property (
    @(posedge clk) disable iff (!arst_n) !(wr_stb && rd_req)
  ) else $error("spi_slave: write strobe and read request together");

  // allow for the synchronizer latency after deselect
  a_miso_idle : assert property (
    @(posedge clk) disable iff (!arst_n) spi_cs_n [*3] |-> !spi_miso
  ) else $error("spi_slave: miso driven while deselected");

endmodule

//--- hw/register_bank.sv
////////////////////////////////////////
// led, mode and direct registers, 32 bits each
// rd_data is valid the clock after rd_req
// unknown addresses ignore writes and read as zero
////////////////////////////////////////

`timescale 1ns/1ns
`include "dmm_settings.svh"

module register_bank (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 wr_stb,
  input  logic                 rd_req,
  input  dmm_pkg::reg_addr_t   addr,
  input  logic [`REG_BITS-1:0] wr_data,
  output logic [`REG_BITS-1:0] rd_data,
  output dmm_pkg::mode_t       reg_mode,
  output logic [`REG_BITS-1:0] reg_direct
);

  logic [`REG_BITS-1:0] reg_led_q;     // test register, read-back only
  logic [`REG_BITS-1:0] reg_mode_q;    // full width kept for read-back
  logic [`REG_BITS-1:0] reg_direct_q;

  ////////////////////////////////////////
  // write decode

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      reg_led_q    <= '0;
      reg_mode_q   <= '0;  // MODE_LO
      reg_direct_q <= '0;
    end
    else if (wr_stb)
    begin
      case (addr)
        dmm_pkg::REG_LED:    reg_led_q    <= wr_data;
        dmm_pkg::REG_MODE:   reg_mode_q   <= wr_data;
        dmm_pkg::REG_DIRECT: reg_direct_q <= wr_data;
        default:             ;  // no such register
      endcase
    end
  end

  ////////////////////////////////////////
  // read-back, captured on the request

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      rd_data <= '0;
    else if (rd_req)
    begin
      case (addr)
        dmm_pkg::REG_LED:    rd_data <= reg_led_q;
        dmm_pkg::REG_MODE:   rd_data <= reg_mode_q;
        dmm_pkg::REG_DIRECT: rd_data <= reg_direct_q;
        default:             rd_data <= '0;
      endcase
    end
  end

  assign reg_mode   = dmm_pkg::mode_t'(reg_mode_q[2:0]);  // 5..7 pass through as is
  assign reg_direct = reg_direct_q;

  // mode must only move as a result of an spi write
  a_mode_from_write : assert property (
    @(posedge clk) disable iff (!arst_n) !$stable(reg_mode) |-> $past(wr_stb)
  ) else $error("register_bank: mode changed without a write");

endmodule

//--- hw/modulation_az.sv
////////////////////////////////////////
// auto-zero sequencer, free running from reset
// alternates pre-charge and zero phases, AZ_PHASE_CYCLES clocks each
// fields not modulated come straight from the direct register
////////////////////////////////////////

`timescale 1ns/1ns
`include "dmm_settings.svh"

module modulation_az (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [`REG_BITS-1:0]  reg_direct,
  output logic [`COND_BITS-1:0] az_word
);

  localparam int CNT_W = $clog2(`AZ_PHASE_CYCLES + 1);  // wide enough to hold the limit

  localparam logic [CNT_W-1:0] PHASE_LAST = CNT_W'(`AZ_PHASE_CYCLES - 1);
  localparam logic [CNT_W-1:0] PHASE_LEN  = CNT_W'(`AZ_PHASE_CYCLES);

  dmm_pkg::az_state_t state_q;
  logic [CNT_W-1:0]   phase_cnt;
  logic               in_pc;        // pre-charge phase
  logic               phase_first;  // first clock of either phase

  ////////////////////////////////////////
  // phase FSM

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q   <= dmm_pkg::AZ_PC;
      phase_cnt <= '0;
    end
    else if (phase_cnt == PHASE_LAST)
    begin
      phase_cnt <= '0;
      state_q   <= (state_q == dmm_pkg::AZ_PC) ? dmm_pkg::AZ_ZERO : dmm_pkg::AZ_PC;
    end
    else
      phase_cnt <= phase_cnt + 1'b1;
  end

  assign in_pc       = (state_q == dmm_pkg::AZ_PC);
  assign phase_first = (phase_cnt == '0);

  ////////////////////////////////////////
  // modulated word

  always_comb
  begin
    // azmux parks on pc node during pre-charge, else the selected input
    az_word[`IDX_AZMUX +: `MUX_BITS]   = in_pc ? `AZMUX_PC_SEL
                                               : reg_direct[`IDX_AZMUX +: `MUX_BITS];
    az_word[`IDX_SIG_PC_SW]            = in_pc;
    az_word[`IDX_LED0]                 = in_pc;  // visible phase on the led
    // mon0 follows phase, mon1 marks each phase start for the scope
    az_word[`IDX_MONITOR +: `MON_BITS] = {{(`MON_BITS - 2){1'b0}}, phase_first, in_pc};

    // not modulated
    az_word[`IDX_HIMUX +: `MUX_BITS]   = reg_direct[`IDX_HIMUX +: `MUX_BITS];
    az_word[`IDX_HIMUX2 +: `MUX_BITS]  = reg_direct[`IDX_HIMUX2 +: `MUX_BITS];
    az_word[`IDX_ADCMUX +: `MUX_BITS]  = reg_direct[`IDX_ADCMUX +: `MUX_BITS];
    az_word[`IDX_CMPR_LATCH]           = reg_direct[`IDX_CMPR_LATCH];
    az_word[`IDX_MEAS_COMPLETE]        = reg_direct[`IDX_MEAS_COMPLETE];
    az_word[`IDX_SPI_INTERRUPT]        = reg_direct[`IDX_SPI_INTERRUPT];
  end

  a_phase_bound : assert property (
    @(posedge clk) disable iff (!arst_n) phase_cnt < PHASE_LEN
  ) else $error("modulation_az: phase count overran");

endmodule

//--- hw/output_select.sv
////////////////////////////////////////
// mode mux onto the conditioning bus, registered
// cond_out lags its selected source by one clock
////////////////////////////////////////

`timescale 1ns/1ns
`include "dmm_settings.svh"

module output_select (
  input  logic                  clk,
  input  logic                  arst_n,
  input  dmm_pkg::mode_t        reg_mode,
  input  logic [`REG_BITS-1:0]  reg_direct,
  input  logic [`COND_BITS-1:0] az_word,
  output logic [`COND_BITS-1:0] cond_out
);

  logic [`COND_BITS-1:0] pattern_cnt;  // test pattern, wraps at 2^29

  ////////////////////////////////////////
  // test pattern

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      pattern_cnt <= '0;
    else
      pattern_cnt <= pattern_cnt + 1'b1;  // every output toggles at its own rate
  end

  ////////////////////////////////////////
  // mode mux

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      cond_out <= '0;
    else
    begin
      case (reg_mode)
        dmm_pkg::MODE_LO:      cond_out <= '0;
        dmm_pkg::MODE_HI:      cond_out <= '1;
        dmm_pkg::MODE_PATTERN: cond_out <= pattern_cnt;
        dmm_pkg::MODE_DIRECT:  cond_out <= reg_direct[`COND_BITS-1:0];  // upper bits unused
        dmm_pkg::MODE_AZ:      cond_out <= az_word;
        default:               cond_out <= '0;  // 5..7 park the bus low
      endcase
    end
  end

endmodule

//--- hw/dmm_top.sv
////////////////////////////////////////
// measurement front end control core
// one clk domain, spi pins oversampled
// cond_out fields are placed by the IDX_ defines
////////////////////////////////////////

`timescale 1ns/1ns
`include "dmm_settings.svh"

module dmm_top (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  spi_clk,
  input  logic                  spi_cs_n,
  input  logic                  spi_mosi,
  output logic                  spi_miso,
  output logic [`COND_BITS-1:0] cond_out
);

  // spi to register bank
  logic                 wr_stb;
  logic                 rd_req;
  dmm_pkg::reg_addr_t   addr;
  logic [`REG_BITS-1:0] wr_data;
  logic [`REG_BITS-1:0] rd_data;

  // register outputs
  dmm_pkg::mode_t        reg_mode;
  logic [`REG_BITS-1:0]  reg_direct;
  logic [`COND_BITS-1:0] az_word;

  spi_slave spi_slave_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .spi_clk  (spi_clk),
    .spi_cs_n (spi_cs_n),
    .spi_mosi (spi_mosi),
    .rd_data  (rd_data),
    .spi_miso (spi_miso),
    .wr_stb   (wr_stb),
    .rd_req   (rd_req),
    .addr     (addr),
    .wr_data  (wr_data)
  );

  register_bank register_bank_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .wr_stb     (wr_stb),
    .rd_req     (rd_req),
    .addr       (addr),
    .wr_data    (wr_data),
    .rd_data    (rd_data),
    .reg_mode   (reg_mode),
    .reg_direct (reg_direct)
  );

  modulation_az modulation_az_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .reg_direct (reg_direct),  // azmux and pass-through fields
    .az_word    (az_word)
  );

  output_select output_select_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .reg_mode   (reg_mode),
    .reg_direct (reg_direct),
    .az_word    (az_word),
    .cond_out   (cond_out)
  );

endmodule

//--- verif/tb_clock.sv
////////////////////////////////////////
// 4 ns free running clock
// active low reset held for 5 cycles, released on a falling edge
////////////////////////////////////////

`timescale 1ns/1ns

module tb_clock (
  output logic clk,
  output logic arst_n
);

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // half period 2 ns
  end

  initial
  begin
    arst_n = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

//--- verif/tb_dmm.sv
////////////////////////////////////////
// table driven testbench for dmm_top, spi mode 0 bit-banged
// spi half period 4 clk, inputs change on falling clk edges
// random direct values from $urandom seeded with 97
////////////////////////////////////////

`timescale 1ns/1ns
`include "dmm_settings.svh"

module tb_dmm;

  typedef enum {OP_IDLE, OP_READ, OP_WRRD, OP_SHORT, OP_MODE, OP_DIRECT,
                OP_PATTERN, OP_AZ} op_t;

  localparam int N_TESTS      = 18;
  localparam int HALF_CLKS    = 4;                                 // spi half period
  localparam int FRAME_CLKS   = `SPI_FRAME_BITS * 2 * HALF_CLKS + HALF_CLKS + 12;
  localparam int WORST_CLKS   = 2 * FRAME_CLKS + 120;              // two frames plus sampling
  localparam int WDOG_CLKS    = N_TESTS * WORST_CLKS * 2;
  localparam logic [31:0] COND_MASK = {{(32 - `COND_BITS){1'b0}}, {`COND_BITS{1'b1}}};

  logic                  clk;
  logic                  arst_n;
  logic                  spi_clk;
  logic                  spi_cs_n;
  logic                  spi_mosi;
  logic                  spi_miso;
  logic [`COND_BITS-1:0] cond_out;

  // stimulus / expected table
  string       t_name [N_TESTS];
  op_t         t_op   [N_TESTS];
  logic [6:0]  t_addr [N_TESTS];
  logic [31:0] t_data [N_TESTS];
  logic [2:0]  t_mode [N_TESTS];
  logic [31:0] t_exp  [N_TESTS];
  int          n_tests;
  int          n_fail;

  tb_clock tb_clock_i (.clk(clk), .arst_n(arst_n));

  dmm_top dut_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .spi_clk  (spi_clk),
    .spi_cs_n (spi_cs_n),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso),
    .cond_out (cond_out)
  );

  ////////////////////////////////////////
  // spi master

  task automatic spi_xfer(input logic [7:0] cmd, input logic [31:0] wdata, input int nbits,
                          output logic [31:0] rdata);
    logic [39:0] frame;
    frame = {cmd, wdata};
    rdata = '0;
    @(negedge clk);
    spi_cs_n = 1'b0;
    spi_mosi = frame[39];  // first bit valid before first rising edge
    for (int i = 0; i < nbits; i++)
    begin
      repeat (HALF_CLKS) @(negedge clk);
      if (i >= 8)
        rdata = {rdata[30:0], spi_miso};  // master samples on rising edge
      spi_clk = 1'b1;
      repeat (HALF_CLKS) @(negedge clk);
      spi_clk = 1'b0;
      if (i < 39)
        spi_mosi = frame[38-i];
    end
    repeat (HALF_CLKS) @(negedge clk);
    spi_cs_n = 1'b1;
    spi_mosi = 1'b0;
    repeat (10) @(negedge clk);  // let registers and cond_out settle
  endtask

  task automatic spi_write(input logic [6:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    spi_xfer({1'b0, addr}, data, `SPI_FRAME_BITS, unused);
  endtask

  task automatic spi_read(input logic [6:0] addr, output logic [31:0] data);
    spi_xfer({1'b1, addr}, 32'h0, `SPI_FRAME_BITS, data);
  endtask

  ////////////////////////////////////////
  // table and result helpers

  task automatic add_test(input string name, input op_t op, input logic [6:0] addr,
                          input logic [31:0] data, input logic [2:0] mode,
                          input logic [31:0] exp);
    if (n_tests < N_TESTS)
    begin
      t_name[n_tests] = name;
      t_op[n_tests]   = op;
      t_addr[n_tests] = addr;
      t_data[n_tests] = data;
      t_mode[n_tests] = mode;
      t_exp[n_tests]  = exp;
      n_tests++;
    end
  endtask

  task automatic report(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      n_fail++;
      $display("Error %s: expected %h, actual %h", name, exp, act);
    end
    else
      $display("ok    %s: %h", name, act);
  endtask

  // auto-zero word checked cycle by cycle against the field rules
  task automatic run_az(input string name, input logic [31:0] dir);
    logic [`COND_BITS-1:0] w;
    logic [`COND_BITS-1:0] exp_w;
    logic [`COND_BITS-1:0] chk;
    logic [`COND_BITS-1:0] mask;
    logic                  pc;
    logic                  new_phase;
    dmm_pkg::az_state_t    phase;
    dmm_pkg::az_state_t    phase_prev;
    int                    run_len;
    int                    n_runs;
    int                    bad_run;
    logic [31:0]           first_exp;
    logic [31:0]           first_act;
    logic                  seen_bad;
    spi_write(dmm_pkg::REG_DIRECT, dir);
    spi_write(dmm_pkg::REG_MODE, 32'(dmm_pkg::MODE_AZ));
    chk = '0;
    chk[`IDX_AZMUX +: `MUX_BITS]   = '1;
    chk[`IDX_HIMUX +: `MUX_BITS]   = '1;
    chk[`IDX_HIMUX2 +: `MUX_BITS]  = '1;
    chk[`IDX_LED0]                 = 1'b1;
    chk[`IDX_MONITOR +: `MON_BITS] = '1;
    chk[`COND_BITS-1:`IDX_ADCMUX]  = '1;   // adcmux and the single bits above
    run_len    = 0;
    n_runs     = 0;
    bad_run    = 0;
    seen_bad   = 1'b0;
    first_exp  = '0;
    first_act  = '0;
    phase_prev = dmm_pkg::AZ_PC;
    for (int i = 0; i < 40; i++)
    begin
      @(negedge clk);
      w         = cond_out;
      pc        = w[`IDX_SIG_PC_SW];
      phase     = pc ? dmm_pkg::AZ_PC : dmm_pkg::AZ_ZERO;
      new_phase = (i > 0) && (phase != phase_prev);
      if (new_phase)
      begin
        if (n_runs > 0 && run_len != `AZ_PHASE_CYCLES && bad_run == 0)
          bad_run = run_len;  // first run may be partial
        n_runs++;
        run_len = 0;
      end
      run_len++;
      phase_prev = phase;
      exp_w = dir[`COND_BITS-1:0];  // pass-through fields
      exp_w[`IDX_AZMUX +: `MUX_BITS] = pc ? `AZMUX_PC_SEL : dir[`IDX_AZMUX +: `MUX_BITS];
      exp_w[`IDX_LED0]    = pc;
      // mon0 follows the phase, mon1 flags the first cycle of a phase, rest low
      exp_w[`IDX_MONITOR +: `MON_BITS] = {{(`MON_BITS - 2){1'b0}}, new_phase, pc};
      mask = chk;
      if (i == 0)
        mask[`IDX_MONITOR + 1] = 1'b0;  // phase start unknown on the first sample
      if ((w & mask) !== (exp_w & mask) && !seen_bad)
      begin
        seen_bad  = 1'b1;
        first_exp = 32'(exp_w & mask);
        first_act = 32'(w & mask);
      end
    end
    if (bad_run != 0)
      report({name, " run length"}, `AZ_PHASE_CYCLES, bad_run);
    else if (n_runs < 2)
    begin
      n_fail++;
      $display("Error %s: pre-charge bit did not toggle within 40 cycles", name);
    end
    else
      report(name, first_exp, first_act);
  endtask

  ////////////////////////////////////////
  // watchdog

  initial
  begin
    repeat (WDOG_CLKS) @(posedge clk);
    $display("watchdog expired, tests did not finish in time");
    $display("STATUS: FAIL");
    $finish;
  end

  ////////////////////////////////////////
  // main sequence

  initial
  begin
    logic [31:0] rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] r4;
    spi_clk  = 1'b0;
    spi_cs_n = 1'b1;
    spi_mosi = 1'b0;
    n_tests  = 0;
    n_fail   = 0;
    void'($urandom(97));
    r0 = $urandom();
    r1 = $urandom();
    r2 = $urandom();
    r3 = $urandom();
    r4 = $urandom();

    add_test("reset_idle",    OP_IDLE,    7'h00, 32'h0, 3'd0, 32'h0);
    add_test("led_wr_rd",     OP_WRRD,    dmm_pkg::REG_LED, 32'hdead_beef, 3'd0, 32'hdead_beef);
    // read-back register still holds the led value here
    add_test("read_unknown",  OP_READ,    7'h15, 32'h0, 3'd0, 32'h0);
    add_test("mode_wr_rd",    OP_WRRD,    dmm_pkg::REG_MODE, 32'h1234_5670, 3'd0, 32'h1234_5670);
    add_test("direct_wr_rd",  OP_WRRD,    dmm_pkg::REG_DIRECT, r0, 3'd0, r0);
    add_test("led_short",     OP_SHORT,   dmm_pkg::REG_LED, 32'h0bad_f00d, 3'd0, 32'hdead_beef);
    add_test("mode_lo",       OP_MODE,    7'h00, 32'h0, dmm_pkg::MODE_LO, 32'h0);
    add_test("mode_hi",       OP_MODE,    7'h00, 32'h0, dmm_pkg::MODE_HI, COND_MASK);
    add_test("mode_5",        OP_MODE,    7'h00, 32'h0, 3'd5, 32'h0);
    add_test("mode_6",        OP_MODE,    7'h00, 32'h0, 3'd6, 32'h0);
    add_test("mode_7",        OP_MODE,    7'h00, 32'h0, 3'd7, 32'h0);
    add_test("direct_rand_0", OP_DIRECT,  7'h00, r1, dmm_pkg::MODE_DIRECT, r1 & COND_MASK);
    add_test("direct_rand_1", OP_DIRECT,  7'h00, r2, dmm_pkg::MODE_DIRECT, r2 & COND_MASK);
    add_test("direct_rand_2", OP_DIRECT,  7'h00, r3, dmm_pkg::MODE_DIRECT, r3 & COND_MASK);
    add_test("pattern_k7",    OP_PATTERN, 7'h00, 32'd7, dmm_pkg::MODE_PATTERN, 32'd7);
    add_test("pattern_k100",  OP_PATTERN, 7'h00, 32'd100, dmm_pkg::MODE_PATTERN, 32'd100);
    add_test("az_rand",       OP_AZ,      7'h00, r4, dmm_pkg::MODE_AZ, 32'h0);
    add_test("az_fixed",      OP_AZ,      7'h00, 32'hf5a5_5a5a, dmm_pkg::MODE_AZ, 32'h0);

    @(posedge arst_n);
    repeat (2) @(negedge clk);

    for (int i = 0; i < n_tests; i++)
    begin
      case (t_op[i])
        OP_IDLE:
          report(t_name[i], t_exp[i], {2'b00, spi_miso, cond_out});  // miso and bus both low
        OP_READ:
        begin
          spi_read(t_addr[i], rd);
          report(t_name[i], t_exp[i], rd);
        end
        OP_WRRD:
        begin
          spi_write(t_addr[i], t_data[i]);
          spi_read(t_addr[i], rd);
          report(t_name[i], t_exp[i], rd);
        end
        OP_SHORT:
        begin
          spi_xfer({1'b0, t_addr[i]}, t_data[i], 20, rd);  // cs rises mid frame
          spi_read(t_addr[i], rd);
          report(t_name[i], t_exp[i], rd);
        end
        OP_MODE:
        begin
          spi_write(dmm_pkg::REG_MODE, 32'(t_mode[i]));
          report(t_name[i], t_exp[i], 32'(cond_out));
        end
        OP_DIRECT:
        begin
          spi_write(dmm_pkg::REG_DIRECT, t_data[i]);
          spi_write(dmm_pkg::REG_MODE, 32'(t_mode[i]));
          report(t_name[i], t_exp[i], 32'(cond_out));
        end
        OP_PATTERN:
        begin
          spi_write(dmm_pkg::REG_MODE, 32'(t_mode[i]));
          a = 32'(cond_out);
          repeat (t_data[i]) @(negedge clk);
          b = 32'(cond_out);
          report(t_name[i], t_exp[i], (b - a) & COND_MASK);  // wraps at 2^29
        end
        OP_AZ:
          run_az(t_name[i], t_data[i]);
        default:
        begin
          n_fail++;
          $display("Error %s: unknown table operation", t_name[i]);
        end
      endcase
    end

    $display("tests run %0d, failed %0d", n_tests, n_fail);
    if (n_fail == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- all.f
+incdir+include
hw/dmm_pkg.sv
hw/spi_slave.sv
hw/register_bank.sv
hw/modulation_az.sv
hw/output_select.sv
hw/dmm_top.sv
verif/tb_clock.sv
verif/tb_dmm.sv
